// ==== include/axis_tx_cfg.svh ====
// Width and depth settings of the AXI4-Stream transmit subsystem, included by RTL and testbench
`ifndef AXIS_TX_CFG_SVH
`define AXIS_TX_CFG_SVH

// Stream data width in bits, a whole number of bytes
`define AXIS_DATA_WIDTH 32

// Sideband widths, all non-zero
`define AXIS_ID_WIDTH   4
`define AXIS_DEST_WIDTH 4
`define AXIS_USER_WIDTH 1

// Entries in the master-side skid buffer, 2 or more
`define AXIS_SKID_DEPTH 4

`endif

// ==== design/axis_tx_pkg.sv ====
// Shared stream and frame types of the transmit subsystem, imported by every RTL module
`include "axis_tx_cfg.svh"

package axis_tx_pkg;

    // Stream fields
    typedef logic [`AXIS_DATA_WIDTH-1:0]   axis_data_t;
    typedef logic [`AXIS_DATA_WIDTH/8-1:0] axis_strb_t;
    typedef logic [`AXIS_ID_WIDTH-1:0]     axis_id_t;
    typedef logic [`AXIS_DEST_WIDTH-1:0]   axis_dest_t;
    typedef logic [`AXIS_USER_WIDTH-1:0]   axis_user_t;

    // Frame length in bytes, 0 is sent as a single byte
    typedef logic [7:0] frame_len_t;

    // One byte of the counting pattern
    typedef logic [7:0] frame_byte_t;

    // Frame source FSM
    typedef enum logic [0:0] {
        S_IDLE = 1'b0,
        S_SEND = 1'b1
    } source_state_e;

endpackage : axis_tx_pkg

// ==== design/gaxi_skid_buffer.sv ====
// Registered valid/ready FIFO with occupancy count, used as the skid stage of a stream master
`timescale 1ns/100ps

module gaxi_skid_buffer #(
    parameter int DEPTH      = 4,
    parameter int DATA_WIDTH = 32
) (
    input  logic                           aclk,
    input  logic                           reset,

    // Write side
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [DATA_WIDTH-1:0]          wr_data,

    // Read side
    output logic                           rd_valid,
    input  logic                           rd_ready,
    output logic [DATA_WIDTH-1:0]          rd_data,
    output logic [$clog2(DEPTH + 1)-1:0]   rd_count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [CW-1:0]         count;
    logic                  wr_fire;
    logic                  rd_fire;

    // A full buffer still accepts a word when one leaves in the same cycle
    assign wr_ready = (count != CW'(DEPTH)) || rd_ready;
    assign rd_valid = (count != '0);
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    assign rd_data  = mem[rd_ptr];
    assign rd_count = count;

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge aclk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : gaxi_skid_buffer

// ==== design/axis_master.sv ====
// AXI4-Stream master stage, registers beats through a skid buffer and reports busy for clock gating
`timescale 1ns/100ps
`include "axis_tx_cfg.svh"

module axis_master #(
    parameter int SKID_DEPTH = `AXIS_SKID_DEPTH
) (
    input  logic                    aclk,
    input  logic                    reset,

    // Beats from the internal source
    input  axis_tx_pkg::axis_data_t fub_axis_tdata,
    input  axis_tx_pkg::axis_strb_t fub_axis_tstrb,
    input  logic                    fub_axis_tlast,
    input  axis_tx_pkg::axis_id_t   fub_axis_tid,
    input  axis_tx_pkg::axis_dest_t fub_axis_tdest,
    input  axis_tx_pkg::axis_user_t fub_axis_tuser,
    input  logic                    fub_axis_tvalid,
    output logic                    fub_axis_tready,

    // Master stream port
    output axis_tx_pkg::axis_data_t m_axis_tdata,
    output axis_tx_pkg::axis_strb_t m_axis_tstrb,
    output logic                    m_axis_tlast,
    output axis_tx_pkg::axis_id_t   m_axis_tid,
    output axis_tx_pkg::axis_dest_t m_axis_tdest,
    output axis_tx_pkg::axis_user_t m_axis_tuser,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,

    output logic                    busy
);

    import axis_tx_pkg::*;

    // Packed word is tdata, tstrb, tlast, tid, tdest, tuser from the top bit down
    localparam int PKT_W = $bits(axis_data_t) + $bits(axis_strb_t) + 1 +
                           $bits(axis_id_t) + $bits(axis_dest_t) + $bits(axis_user_t);
    localparam int CW    = $clog2(SKID_DEPTH + 1);

    logic [PKT_W-1:0] wr_pkt;
    logic [PKT_W-1:0] rd_pkt;
    logic [CW-1:0]    skid_count;

    assign wr_pkt = {fub_axis_tdata, fub_axis_tstrb, fub_axis_tlast,
                     fub_axis_tid, fub_axis_tdest, fub_axis_tuser};

    gaxi_skid_buffer #(
        .DEPTH      (SKID_DEPTH),
        .DATA_WIDTH (PKT_W)
    ) t_skid (
        .aclk       (aclk),
        .reset      (reset),
        .wr_valid   (fub_axis_tvalid),
        .wr_ready   (fub_axis_tready),
        .wr_data    (wr_pkt),
        .rd_valid   (m_axis_tvalid),
        .rd_ready   (m_axis_tready),
        .rd_data    (rd_pkt),
        .rd_count   (skid_count)
    );

    assign {m_axis_tdata, m_axis_tstrb, m_axis_tlast,
            m_axis_tid, m_axis_tdest, m_axis_tuser} = rd_pkt;

    // Stored words or a beat on offer keep the stage busy
    assign busy = (skid_count != '0) || fub_axis_tvalid;

endmodule : axis_master

// ==== design/axis_frame_source.sv ====
// Frame source, turns length/id/dest/start commands into counting-byte stream beats
`timescale 1ns/100ps

module axis_frame_source (
    input  logic                     aclk,
    input  logic                     reset,

    // Command port
    input  axis_tx_pkg::frame_len_t  cmd_len,
    input  axis_tx_pkg::axis_id_t    cmd_id,
    input  axis_tx_pkg::axis_dest_t  cmd_dest,
    input  axis_tx_pkg::frame_byte_t cmd_start,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,

    // Beats towards the master stage
    output axis_tx_pkg::axis_data_t  fub_axis_tdata,
    output axis_tx_pkg::axis_strb_t  fub_axis_tstrb,
    output logic                     fub_axis_tlast,
    output axis_tx_pkg::axis_id_t    fub_axis_tid,
    output axis_tx_pkg::axis_dest_t  fub_axis_tdest,
    output axis_tx_pkg::axis_user_t  fub_axis_tuser,
    output logic                     fub_axis_tvalid,
    input  logic                     fub_axis_tready,

    output logic                     active
);

    import axis_tx_pkg::*;

    localparam int BYTES = $bits(axis_strb_t);

    source_state_e state;
    frame_len_t    rem_bytes;
    frame_byte_t   next_byte;
    axis_id_t      frame_id;
    axis_dest_t    frame_dest;
    logic          first_beat;
    logic          cmd_fire;
    logic          beat_fire;

    assign cmd_ready = (state == S_IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign beat_fire = fub_axis_tvalid && fub_axis_tready;
    assign active    = (state == S_SEND);

    // FSM and byte counter
    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= S_IDLE;
            rem_bytes <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_fire) begin
                        state     <= S_SEND;
                        // A zero length still sends one byte
                        rem_bytes <= (cmd_len == '0) ? frame_len_t'(1) : cmd_len;
                    end
                end
                S_SEND: begin
                    if (beat_fire) begin
                        rem_bytes <= fub_axis_tlast ? '0 : rem_bytes - frame_len_t'(BYTES);
                        if (fub_axis_tlast) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Frame fields, loaded per command
    always_ff @(posedge aclk) begin
        if (cmd_fire) begin
            frame_id   <= cmd_id;
            frame_dest <= cmd_dest;
            next_byte  <= cmd_start;
            first_beat <= 1'b1;
        end else if (beat_fire) begin
            next_byte  <= next_byte + frame_byte_t'(BYTES);
            first_beat <= 1'b0;
        end
    end

    // Beat assembly, lane j carries next_byte + j
    always_comb begin
        for (int j = 0; j < BYTES; j++) begin
            fub_axis_tdata[8*j +: 8] = next_byte + frame_byte_t'(j);
            fub_axis_tstrb[j]        = (rem_bytes > frame_len_t'(j));
        end
    end

    assign fub_axis_tlast  = (rem_bytes <= frame_len_t'(BYTES));
    assign fub_axis_tuser  = axis_user_t'(first_beat);
    assign fub_axis_tid    = frame_id;
    assign fub_axis_tdest  = frame_dest;
    assign fub_axis_tvalid = (state == S_SEND);

endmodule : axis_frame_source

// ==== design/axis_tx_top.sv ====
// Top of the AXI4-Stream transmit subsystem, frame source feeding the stream master
`timescale 1ns/100ps
`include "axis_tx_cfg.svh"

module axis_tx_top (
    input  logic                     aclk,
    input  logic                     reset,

    // Frame commands
    input  axis_tx_pkg::frame_len_t  cmd_len,
    input  axis_tx_pkg::axis_id_t    cmd_id,
    input  axis_tx_pkg::axis_dest_t  cmd_dest,
    input  axis_tx_pkg::frame_byte_t cmd_start,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,

    // Master stream port
    output axis_tx_pkg::axis_data_t  m_axis_tdata,
    output axis_tx_pkg::axis_strb_t  m_axis_tstrb,
    output logic                     m_axis_tlast,
    output axis_tx_pkg::axis_id_t    m_axis_tid,
    output axis_tx_pkg::axis_dest_t  m_axis_tdest,
    output axis_tx_pkg::axis_user_t  m_axis_tuser,
    output logic                     m_axis_tvalid,
    input  logic                     m_axis_tready,

    output logic                     busy
);

    import axis_tx_pkg::*;

    // Source to master
    axis_data_t fub_axis_tdata;
    axis_strb_t fub_axis_tstrb;
    logic       fub_axis_tlast;
    axis_id_t   fub_axis_tid;
    axis_dest_t fub_axis_tdest;
    axis_user_t fub_axis_tuser;
    logic       fub_axis_tvalid;
    logic       fub_axis_tready;
    logic       src_active;
    logic       mst_busy;

    axis_frame_source src0 (
        .aclk            (aclk),
        .reset           (reset),
        .cmd_len         (cmd_len),
        .cmd_id          (cmd_id),
        .cmd_dest        (cmd_dest),
        .cmd_start       (cmd_start),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .fub_axis_tdata  (fub_axis_tdata),
        .fub_axis_tstrb  (fub_axis_tstrb),
        .fub_axis_tlast  (fub_axis_tlast),
        .fub_axis_tid    (fub_axis_tid),
        .fub_axis_tdest  (fub_axis_tdest),
        .fub_axis_tuser  (fub_axis_tuser),
        .fub_axis_tvalid (fub_axis_tvalid),
        .fub_axis_tready (fub_axis_tready),
        .active          (src_active)
    );

    axis_master #(
        .SKID_DEPTH      (`AXIS_SKID_DEPTH)
    ) mst0 (
        .aclk            (aclk),
        .reset           (reset),
        .fub_axis_tdata  (fub_axis_tdata),
        .fub_axis_tstrb  (fub_axis_tstrb),
        .fub_axis_tlast  (fub_axis_tlast),
        .fub_axis_tid    (fub_axis_tid),
        .fub_axis_tdest  (fub_axis_tdest),
        .fub_axis_tuser  (fub_axis_tuser),
        .fub_axis_tvalid (fub_axis_tvalid),
        .fub_axis_tready (fub_axis_tready),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tstrb    (m_axis_tstrb),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tid      (m_axis_tid),
        .m_axis_tdest    (m_axis_tdest),
        .m_axis_tuser    (m_axis_tuser),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tready   (m_axis_tready),
        .busy            (mst_busy)
    );

    // Clock gate request covers the source FSM and the buffered beats
    assign busy = src_active || mst_busy;

endmodule : axis_tx_top

// ==== tests/axis_tx_sva.sv ====
// Stream protocol assertions on the transmit subsystem top level, attached to axis_tx_top by bind
`timescale 1ns/100ps

module axis_tx_sva (
    input logic                    aclk,
    input logic                    reset,
    input logic                    cmd_ready,
    input axis_tx_pkg::axis_data_t m_axis_tdata,
    input axis_tx_pkg::axis_strb_t m_axis_tstrb,
    input logic                    m_axis_tlast,
    input axis_tx_pkg::axis_id_t   m_axis_tid,
    input axis_tx_pkg::axis_dest_t m_axis_tdest,
    input axis_tx_pkg::axis_user_t m_axis_tuser,
    input logic                    m_axis_tvalid,
    input logic                    m_axis_tready,
    input logic                    busy
);

    // A stalled beat holds until the sink takes it
    property stall_stable;
        @(posedge aclk) disable iff (reset)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb) &&
             $stable(m_axis_tlast) && $stable(m_axis_tid) && $stable(m_axis_tdest) &&
             $stable(m_axis_tuser));
    endproperty

    stall_stable_a: assert property (stall_stable)
        else $error("m_axis beat changed while tready was low");

    idle_after_reset_a: assert property (
        @(posedge aclk) reset |=> (cmd_ready && !m_axis_tvalid && !busy))
        else $error("subsystem not idle after reset");

    busy_with_valid_a: assert property (
        @(posedge aclk) disable iff (reset) m_axis_tvalid |-> busy)
        else $error("busy low while m_axis_tvalid high");

endmodule : axis_tx_sva

bind axis_tx_top axis_tx_sva sva0 (
    .aclk          (aclk),
    .reset         (reset),
    .cmd_ready     (cmd_ready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .busy          (busy)
);

// ==== tests/tb_axis_tx_top.sv ====
// Testbench for axis_tx_top, random frame commands and back-pressure checked against a beat model
`timescale 1ns/100ps
`include "axis_tx_cfg.svh"

module tb_axis_tx_top;

    import axis_tx_pkg::*;

    localparam int NUM_CMDS    = 200;
    localparam int CYCLE_LIMIT = NUM_CMDS * 64 * 4 + 2000;
    localparam int BYTES       = `AXIS_DATA_WIDTH / 8;
    localparam int RDY_RANDOM  = 0;
    localparam int RDY_HIGH    = 1;
    localparam int RDY_LOW     = 2;

    typedef struct packed {
        frame_len_t  len;
        axis_id_t    id;
        axis_dest_t  dest;
        frame_byte_t start;
    } cmd_t;

    typedef struct packed {
        axis_data_t data;
        axis_strb_t strb;
        logic       last;
        axis_user_t user;
    } beat_t;

    logic        aclk = 1'b0;
    logic        reset;
    frame_len_t  cmd_len;
    axis_id_t    cmd_id;
    axis_dest_t  cmd_dest;
    frame_byte_t cmd_start;
    logic        cmd_valid;
    logic        cmd_ready;
    axis_data_t  m_axis_tdata;
    axis_strb_t  m_axis_tstrb;
    logic        m_axis_tlast;
    axis_id_t    m_axis_tid;
    axis_dest_t  m_axis_tdest;
    axis_user_t  m_axis_tuser;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        busy;

    integer      seed       = 27;
    int          ready_mode = RDY_HIGH;
    cmd_t        cmd_list [NUM_CMDS];
    int          gap_list [NUM_CMDS];
    cmd_t        exp_q [$];
    beat_t       ref_beat;
    axis_data_t  held_data;
    logic        gap_check;
    int          beat_idx;
    int          beats_seen;
    int          frames_seen;
    int          errors;
    int          cycle_count;

    axis_tx_top dut0 (.*);

    always #4 aclk = ~aclk;

    // Beat k of a frame, lane j holds start + BYTES*k + j
    function automatic beat_t expected_beat(input cmd_t c, input int k);
        beat_t b;
        int    len;
        int    nbeats;
        len    = (c.len == 0) ? 1 : int'(c.len);
        nbeats = (len + BYTES - 1) / BYTES;
        for (int j = 0; j < BYTES; j++) begin
            b.data[8*j +: 8] = 8'((int'(c.start) + BYTES * k + j) % 256);
            b.strb[j]        = (k < nbeats - 1) || (j < len - BYTES * k);
        end
        b.last = (k == nbeats - 1);
        b.user = axis_user_t'(k == 0);
        return b;
    endfunction

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("Error at %0t: %s got %h expected %h", $time, field, got, want);
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_cmd(input cmd_t c, input int gap);
        cmd_len   = c.len;
        cmd_id    = c.id;
        cmd_dest  = c.dest;
        cmd_start = c.start;
        cmd_valid = 1'b1;
        @(posedge aclk);
        while (!cmd_ready)
            @(posedge aclk);
        exp_q.push_back(c);
        @(negedge aclk);
        if (gap > 0) begin
            cmd_valid = 1'b0;
            repeat (gap) @(negedge aclk);
        end
    endtask

    // Mode changes on a rising edge so the ready driver sees it on the next falling edge
    task automatic set_ready_mode(input int mode);
        @(posedge aclk);
        ready_mode = mode;
        @(negedge aclk);
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0 || busy)
            @(negedge aclk);
    endtask

    always @(negedge aclk) begin
        if (ready_mode == RDY_HIGH)
            m_axis_tready = 1'b1;
        else if (ready_mode == RDY_LOW)
            m_axis_tready = 1'b0;
        else
            m_axis_tready = 1'($random(seed));
    end

    // Checker on every m_axis transfer
    always @(posedge aclk) begin
        if (!reset && gap_check && beat_idx != 0 && m_axis_tready && !m_axis_tvalid) begin
            errors++;
            $display("Error at %0t: gap inside a frame with tready high", $time);
        end
        if (!reset && m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A beat arrived at %0t with no command outstanding", $time);
            end else begin
                ref_beat = expected_beat(exp_q[0], beat_idx);
                if (m_axis_tdata !== ref_beat.data)
                    report_mismatch("tdata", m_axis_tdata, ref_beat.data);
                if (m_axis_tstrb !== ref_beat.strb)
                    report_mismatch("tstrb", 32'(m_axis_tstrb), 32'(ref_beat.strb));
                if (m_axis_tlast !== ref_beat.last)
                    report_mismatch("tlast", 32'(m_axis_tlast), 32'(ref_beat.last));
                if (m_axis_tuser !== ref_beat.user)
                    report_mismatch("tuser", 32'(m_axis_tuser), 32'(ref_beat.user));
                if (m_axis_tid !== exp_q[0].id)
                    report_mismatch("tid", 32'(m_axis_tid), 32'(exp_q[0].id));
                if (m_axis_tdest !== exp_q[0].dest)
                    report_mismatch("tdest", 32'(m_axis_tdest), 32'(exp_q[0].dest));
                beats_seen++;
                if (ref_beat.last) begin
                    void'(exp_q.pop_front());
                    beat_idx = 0;
                    frames_seen++;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("The run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int pick;
        reset         = 1'b1;
        cmd_len       = '0;
        cmd_id        = '0;
        cmd_dest      = '0;
        cmd_start     = '0;
        cmd_valid     = 1'b0;
        m_axis_tready = 1'b0;
        gap_check     = 1'b0;
        beat_idx      = 0;
        beats_seen    = 0;
        frames_seen   = 0;
        errors        = 0;
        // Lengths 1 to 16 first, then a 64 byte frame for the stall, then random
        for (int i = 0; i < NUM_CMDS; i++) begin
            cmd_list[i].id    = axis_id_t'($random(seed));
            cmd_list[i].dest  = axis_dest_t'($random(seed));
            cmd_list[i].start = frame_byte_t'($random(seed));
            pick              = $unsigned($random(seed)) % 8;
            gap_list[i]       = (i < 17) ? 0 : $unsigned($random(seed)) % 4;
            if (i < 16)
                cmd_list[i].len = frame_len_t'(i + 1);
            else if (i == 16)
                cmd_list[i].len = 8'd64;
            else if (pick == 0)
                cmd_list[i].len = 8'd0;
            else if (pick < 4)
                cmd_list[i].len = frame_len_t'(1 + $unsigned($random(seed)) % 8);
            else
                cmd_list[i].len = frame_len_t'(1 + $unsigned($random(seed)) % 255);
        end

        repeat (16) @(negedge aclk);
        reset = 1'b0;
        if (m_axis_tvalid !== 1'b0 || busy !== 1'b0 || cmd_ready !== 1'b1) begin
            errors++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end

        // Back-to-back frames, sink always ready
        set_ready_mode(RDY_HIGH);
        gap_check = 1'b1;
        for (int i = 0; i < 16; i++)
            send_cmd(cmd_list[i], 0);
        cmd_valid = 1'b0;
        wait_for_drain();
        gap_check = 1'b0;

        // Sink stalled for 20 cycles under a long frame
        set_ready_mode(RDY_LOW);
        send_cmd(cmd_list[16], 1);
        while (!m_axis_tvalid)
            @(negedge aclk);
        held_data = m_axis_tdata;
        repeat (20) begin
            @(negedge aclk);
            if (m_axis_tvalid !== 1'b1)
                report_mismatch("tvalid during stall", 32'(m_axis_tvalid), 32'd1);
            if (m_axis_tdata !== held_data)
                report_mismatch("tdata during stall", m_axis_tdata, held_data);
            if (busy !== 1'b1)
                report_mismatch("busy during stall", 32'(busy), 32'd1);
        end

        set_ready_mode(RDY_RANDOM);
        for (int i = 17; i < NUM_CMDS; i++)
            send_cmd(cmd_list[i], gap_list[i]);
        cmd_valid = 1'b0;
        wait_for_drain();

        $display("Frames %0d, beats %0d, errors %0d", frames_seen, beats_seen, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_axis_tx_top

// ==== all.f ====
+incdir+include
design/axis_tx_pkg.sv
design/gaxi_skid_buffer.sv
design/axis_master.sv
design/axis_frame_source.sv
design/axis_tx_top.sv
tests/axis_tx_sva.sv
tests/tb_axis_tx_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_axis_tx_top -f all.f -o sim_tb
	@./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
